// File: compile.f
rtl/qspi_reg_pkg.sv
rtl/qspi_link_pkg.sv
rtl/qspi_regs.sv
rtl/qspi_sclk_gen.sv
rtl/qspi_sequencer.sv
rtl/qspi_master.sv
verification/qspi_flash_model.sv
verification/tb_qspi_master.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_qspi_master
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/tb_qspi_master.sv
`timescale 1ns/100ps

module tb_qspi_master
    import qspi_reg_pkg::*;
    import qspi_link_pkg::*;
();

    localparam int NUM_ROWS     = 6;
    localparam int NUM_RB       = 7;
    localparam int LIMIT_MARGIN = 1000;

    typedef struct packed {
        logic [7:0]  cmd;
        lane_mode_e  lane;
        logic        write;
        logic        addr_en;
        logic [3:0]  dummy;
        logic [3:0]  words;
        prescale_t   prescaler;
        logic [23:0] addr;
        logic        poke;
    } row_t;

    typedef struct packed {
        reg_addr_t addr;
        byte_en_t  be;
        reg_word_t wdata;
        reg_word_t exp_data;
    } rb_t;

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic        write_i;
    byte_en_t    data_be_i;
    reg_addr_t   addr_i;
    reg_word_t   wdata_i;
    reg_word_t   rdata_o;
    logic        sclk_o;
    logic        cs_n_o;
    qspi_pads_t  pads_o;
    logic [3:0]  io_i;
    ccr_t        flash_cfg;
    logic [7:0]  flash_cmd;
    logic [23:0] flash_addr;
    int          flash_edges;
    int          flash_nbytes;
    int          flash_hmin;
    int          flash_hmax;
    logic        flash_conflict;

    row_t        rows [NUM_ROWS];
    rb_t         rb [NUM_RB];
    int unsigned cycles = 0;
    int unsigned cycle_limit = 32'hffff_ffff;

    always #20 clk_i = ~clk_i;

    qspi_master u_dut (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .write_i   (write_i),
        .data_be_i (data_be_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .rdata_o   (rdata_o),
        .sclk_o    (sclk_o),
        .cs_n_o    (cs_n_o),
        .pads_o    (pads_o),
        .io_i      (io_i)
    );

    qspi_flash_model u_flash (
        .sclk_i     (sclk_o),
        .cs_n_i     (cs_n_o),
        .pads_i     (pads_o),
        .cfg_i      (flash_cfg),
        .io_o       (io_i),
        .cmd_o      (flash_cmd),
        .addr_o     (flash_addr),
        .edges_o    (flash_edges),
        .nbytes_o   (flash_nbytes),
        .high_min_o (flash_hmin),
        .high_max_o (flash_hmax),
        .conflict_o (flash_conflict)
    );

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Command-control word laid out from bit 31 down
    function automatic reg_word_t ccr_word(input row_t r, input logic start);
        return {start, r.prescaler, 6'd0, 3'(r.words - 4'd1), r.dummy,
                r.addr_en, r.write, r.lane, r.cmd};
    endfunction

    function automatic int frame_clocks(input row_t r);
        int n;
        n = 8 + (r.addr_en ? 24 : 0) + int'(r.dummy);
        case (r.lane)
            LANE_X1: n = n + 32 * int'(r.words);
            LANE_X2: n = n + 16 * int'(r.words);
            LANE_X4: n = n + 8 * int'(r.words);
            default: n = n;
        endcase
        return n;
    endfunction

    function automatic reg_word_t read_word(input logic [7:0] low_addr, input int w);
        reg_word_t v;
        for (int b = 0; b < 4; b++) begin
            v[8*b +: 8] = low_addr ^ 8'(4*w + b) ^ 8'h5a;
        end
        return v;
    endfunction

    function automatic int unsigned run_limit();
        int unsigned total;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total = total + (8 + 24 + rows[r].dummy + 32 * rows[r].words)
                          * 2 * (rows[r].prescaler + 1);
        end
        return total + LIMIT_MARGIN;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Bus tasks start and end on a falling clock edge
    task automatic bus_write(input reg_addr_t a, input byte_en_t be, input reg_word_t d);
        write_i   = 1'b1;
        addr_i    = a;
        data_be_i = be;
        wdata_i   = d;
        @(negedge clk_i);
        write_i   = 1'b0;
    endtask

    task automatic bus_read(input reg_addr_t a, output reg_word_t d);
        addr_i = a;
        @(negedge clk_i);
        d = rdata_o;
    endtask

    task automatic wait_idle();
        reg_word_t sta;
        sta = 32'h1;
        while (sta[0]) begin
            bus_read(STA_OFS, sta);
        end
    endtask

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the DUT did not go idle within %0d cycles", cycles);
            $display("TESTS FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        row_t        row;
        reg_word_t   rd;
        reg_word_t   exp_buf [BUF_WORDS];
        logic [31:0] rng;
        rst_i     = 1'b1;
        write_i   = 1'b0;
        data_be_i = '0;
        addr_i    = '0;
        wdata_i   = '0;
        flash_cfg = '0;
        rng       = 32'h446e;

        //        cmd    lane      wr    aen   dummy  words  presc  addr        poke
        rows[0] = '{8'h02, LANE_X1,   1'b1, 1'b1, 4'd0, 4'd2, 6'd1, 24'h012345, 1'b0};
        rows[1] = '{8'h32, LANE_X4,   1'b1, 1'b1, 4'd2, 4'd3, 6'd0, 24'h00a0c3, 1'b0};
        rows[2] = '{8'h0b, LANE_X1,   1'b0, 1'b1, 4'd8, 4'd2, 6'd2, 24'h1000f1, 1'b0};
        rows[3] = '{8'h3b, LANE_X2,   1'b0, 1'b1, 4'd8, 4'd4, 6'd1, 24'h2222a5, 1'b1};
        rows[4] = '{8'h6b, LANE_X4,   1'b0, 1'b1, 4'd8, 4'd8, 6'd0, 24'h7f0010, 1'b0};
        rows[5] = '{8'h06, LANE_NONE, 1'b0, 1'b0, 4'd0, 4'd1, 6'd3, 24'h000000, 1'b0};

        // Start bit and reserved field of CCR read back as zero
        rb[0] = '{CCR_OFS,      4'b1111, 32'h7fff_ffff, 32'h7e07_ffff};
        rb[1] = '{CCR_OFS,      4'b0010, 32'h0000_0000, 32'h7e07_00ff};
        rb[2] = '{ADR_OFS,      4'b1111, 32'hffa1_b2c3, 32'h00a1_b2c3};
        rb[3] = '{ADR_OFS,      4'b0101, 32'h0011_2233, 32'h0011_b233};
        rb[4] = '{DR_OFS + 20,  4'b1111, 32'hdead_beef, 32'hdead_beef};
        rb[5] = '{DR_OFS + 20,  4'b1010, 32'h0123_4567, 32'h01ad_45ef};
        rb[6] = '{STA_OFS,      4'b1111, 32'hffff_ffff, 32'h0000_0000};

        cycle_limit = run_limit();
        repeat (4) @(negedge clk_i);
        rst_i = 1'b0;

        check("cs_n_o", cs_n_o, 1'b1);
        check("sclk_o", sclk_o, 1'b0);
        check("pads_o.io_oe", pads_o.io_oe, 4'h0);
        bus_read(STA_OFS, rd);
        check("sta", rd, 32'h0);

        for (int i = 0; i < NUM_RB; i++) begin
            bus_write(rb[i].addr, rb[i].be, rb[i].wdata);
            bus_read(rb[i].addr, rd);
            check($sformatf("rdata_o at %h", rb[i].addr), rd, rb[i].exp_data);
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            row = rows[r];
            for (int w = 0; w < int'(row.words); w++) begin
                rng        = xorshift32(rng);
                exp_buf[w] = rng;
                bus_write(DR_OFS + reg_addr_t'(4*w), 4'hf, rng);
            end
            bus_write(ADR_OFS, 4'hf, {8'h00, row.addr});
            flash_cfg = ccr_t'(ccr_word(row, 1'b0));
            bus_write(CCR_OFS, 4'hf, ccr_word(row, 1'b1));
            check("cs_n_o", cs_n_o, 1'b0);
            // A second start in the middle of the frame must change nothing
            if (row.poke) begin
                bus_write(CCR_OFS, 4'hf, 32'hffff_ffff);
            end
            wait_idle();

            check("cs_n_o", cs_n_o, 1'b1);
            check("sclk_o", sclk_o, 1'b0);
            check("pads_o.io_oe", pads_o.io_oe, 4'h0);
            bus_read(CCR_OFS, rd);
            check("ccr", rd, ccr_word(row, 1'b0));
            check("flash_cmd", flash_cmd, row.cmd);
            if (row.addr_en) begin
                check("flash_addr", flash_addr, row.addr);
            end
            check("flash_edges", flash_edges, frame_clocks(row));
            check("flash_conflict", flash_conflict, 1'b0);
            check("sclk high min", flash_hmin, 32'((row.prescaler + 1) * 40));
            check("sclk high max", flash_hmax, 32'((row.prescaler + 1) * 40));

            if (row.lane != LANE_NONE && row.write) begin
                check("flash_nbytes", flash_nbytes, 4 * int'(row.words));
                for (int n = 0; n < 4 * int'(row.words); n++) begin
                    check($sformatf("flash byte %0d", n), u_flash.wr_bytes[n],
                          exp_buf[n/4][8*(n%4) +: 8]);
                end
            end else if (row.lane != LANE_NONE) begin
                for (int w = 0; w < int'(row.words); w++) begin
                    bus_read(DR_OFS + reg_addr_t'(4*w), rd);
                    check($sformatf("dr%0d", w), rd, read_word(row.addr[7:0], w));
                end
            end
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: verification/qspi_flash_model.sv
`timescale 1ns/100ps

module qspi_flash_model
    import qspi_reg_pkg::*;
    import qspi_link_pkg::*;
(
    input  logic        sclk_i,
    input  logic        cs_n_i,
    input  qspi_pads_t  pads_i,
    input  ccr_t        cfg_i,
    output logic [3:0]  io_o,
    output logic [7:0]  cmd_o,
    output logic [23:0] addr_o,
    output int          edges_o,
    output int          nbytes_o,
    output int          high_min_o,
    output int          high_max_o,
    output logic        conflict_o
);

    logic [7:0] wr_bytes [4*BUF_WORDS];
    logic [3:0] drv = '0;
    logic [3:0] drv_en = '0;
    logic [7:0] byte_sh;
    int         nbits;
    int         frame_cnt = 0;
    int         rise_frame = 0;
    int         fall_frame = 0;
    time        t_rise;

    function automatic int lane_width(input logic [1:0] mode);
        case (lane_mode_e'(mode))
            LANE_X2: return 2;
            LANE_X4: return 4;
            default: return 1;
        endcase
    endfunction

    function automatic logic [3:0] lane_mask(input int lw);
        return 4'((1 << lw) - 1);
    endfunction

    // Index of the serial clock that carries the first data bits
    function automatic int first_data_clock(input ccr_t cfg);
        return 8 + (cfg.addr_en ? 24 : 0) + int'(cfg.dummy_cycles);
    endfunction

    function automatic int data_clocks(input ccr_t cfg);
        if (lane_mode_e'(cfg.lane_mode) == LANE_NONE) begin
            return 0;
        end
        return (int'(cfg.word_count_m1) + 1) * 32 / lane_width(cfg.lane_mode);
    endfunction

    // Lines that nobody drives are pulled high
    assign io_o = (pads_i.io_oe & pads_i.io_o) | (~pads_i.io_oe & (~drv_en | drv));

    always @(negedge cs_n_i) begin
        frame_cnt <= frame_cnt + 1;
    end

    ////////////////////////////////////////////////////////////
    // Sampling on the rising serial clock
    ////////////////////////////////////////////////////////////

    always @(posedge sclk_i) begin
        int slot;
        int lw;
        lw   = lane_width(cfg_i.lane_mode);
        if (rise_frame != frame_cnt) begin
            rise_frame = frame_cnt;
            edges_o    = 0;
            cmd_o      = '0;
            addr_o     = '0;
            nbytes_o   = 0;
            nbits      = 0;
            conflict_o = 1'b0;
        end
        t_rise     = $time;
        conflict_o = conflict_o | (|(drv_en & pads_i.io_oe));
        slot       = edges_o - first_data_clock(cfg_i);
        if (edges_o < 8) begin
            cmd_o = {cmd_o[6:0], io_o[0]};
        end else if (cfg_i.addr_en && edges_o < 32) begin
            addr_o = {addr_o[22:0], io_o[0]};
        end else if (cfg_i.write && slot >= 0 && slot < data_clocks(cfg_i)) begin
            byte_sh = (byte_sh << lw) | {4'h0, io_o & lane_mask(lw)};
            nbits   = nbits + lw;
            if (nbits == 8) begin
                if (nbytes_o < 4*BUF_WORDS) begin
                    wr_bytes[nbytes_o] = byte_sh;
                end
                nbytes_o = nbytes_o + 1;
                nbits    = 0;
            end
        end
        edges_o = edges_o + 1;
    end

    ////////////////////////////////////////////////////////////
    // Read data launch on the falling serial clock
    ////////////////////////////////////////////////////////////

    always @(negedge sclk_i) begin
        int         slot;
        int         lw;
        int         k;
        int         high;
        logic [7:0] rd_byte;
        logic [3:0] chunk;
        if (fall_frame != frame_cnt) begin
            fall_frame = frame_cnt;
            high_min_o = 32'h7fff_ffff;
            high_max_o = 0;
        end
        high = int'($time - t_rise);
        if (high < high_min_o) begin
            high_min_o = high;
        end
        if (high > high_max_o) begin
            high_max_o = high;
        end
        lw     = lane_width(cfg_i.lane_mode);
        slot   = edges_o - first_data_clock(cfg_i);
        drv    = '0;
        drv_en = '0;
        if (!cfg_i.write && slot >= 0 && slot < data_clocks(cfg_i)) begin
            // Byte n of the reply is the low address byte mixed with n
            rd_byte = addr_o[7:0] ^ 8'(slot * lw / 8) ^ 8'h5a;
            k       = slot % (8 / lw);
            chunk   = 4'((rd_byte >> (8 - (k + 1) * lw)) & {4'h0, lane_mask(lw)});
            if (lw == 1) begin
                drv    = {2'b00, chunk[0], 1'b0};
                drv_en = 4'b0010;
            end else begin
                drv    = chunk;
                drv_en = lane_mask(lw);
            end
        end
    end

endmodule

// File: rtl/qspi_master.sv
`timescale 1ns/100ps

module qspi_master
    import qspi_reg_pkg::*;
    import qspi_link_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       write_i,
    input  byte_en_t   data_be_i,
    input  reg_addr_t  addr_i,
    input  reg_word_t  wdata_i,
    output reg_word_t  rdata_o,
    output logic       sclk_o,
    output logic       cs_n_o,
    output qspi_pads_t pads_o,
    input  logic [3:0] io_i
);

    ccr_t                 ccr;
    logic [ADDR_BITS-1:0] flash_addr;
    logic                 start;
    reg_word_t            buf_word;
    logic                 busy;
    buf_idx_t             buf_idx;
    logic                 cap_valid;
    reg_word_t            cap_word;
    logic                 run;
    logic                 sclk_rise;
    logic                 sclk_fall;

    qspi_regs u_regs (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .write_i      (write_i),
        .data_be_i    (data_be_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .rdata_o      (rdata_o),
        .busy_i       (busy),
        .buf_idx_i    (buf_idx),
        .cap_valid_i  (cap_valid),
        .cap_word_i   (cap_word),
        .ccr_o        (ccr),
        .flash_addr_o (flash_addr),
        .start_o      (start),
        .buf_word_o   (buf_word)
    );

    qspi_sclk_gen u_sclk_gen (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .run_i       (run),
        .prescaler_i (ccr.prescaler),
        .sclk_o      (sclk_o),
        .sclk_rise_o (sclk_rise),
        .sclk_fall_o (sclk_fall)
    );

    qspi_sequencer u_sequencer (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .start_i      (start),
        .ccr_i        (ccr),
        .flash_addr_i (flash_addr),
        .buf_word_i   (buf_word),
        .sclk_rise_i  (sclk_rise),
        .sclk_fall_i  (sclk_fall),
        .io_i         (io_i),
        .pads_o       (pads_o),
        .cs_n_o       (cs_n_o),
        .run_o        (run),
        .busy_o       (busy),
        .buf_idx_o    (buf_idx),
        .cap_valid_o  (cap_valid),
        .cap_word_o   (cap_word)
    );

endmodule

// File: rtl/qspi_sequencer.sv
`timescale 1ns/100ps

module qspi_sequencer
    import qspi_reg_pkg::*;
    import qspi_link_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 start_i,
    input  ccr_t                 ccr_i,
    input  logic [ADDR_BITS-1:0] flash_addr_i,
    input  reg_word_t            buf_word_i,
    input  logic                 sclk_rise_i,
    input  logic                 sclk_fall_i,
    input  logic [3:0]           io_i,
    output qspi_pads_t           pads_o,
    output logic                 cs_n_o,
    output logic                 run_o,
    output logic                 busy_o,
    output buf_idx_t             buf_idx_o,
    output logic                 cap_valid_o,
    output reg_word_t            cap_word_o
);

    seq_state_e           state_q;
    seq_state_e           next_phase;
    lane_mode_e           lane_q;
    logic                 wr_q;
    logic                 addr_en_q;
    logic [3:0]           dummy_q;
    buf_idx_t             words_m1_q;
    logic [ADDR_BITS-1:0] addr_q;
    bit_cnt_t             bit_cnt_q;
    buf_idx_t             word_cnt_q;
    buf_idx_t             buf_idx_q;
    logic                 cs_n_q;
    logic                 cap_valid_q;
    reg_word_t            cap_word_q;
    reg_word_t            out_sh_q;
    reg_word_t            in_sh_q;
    reg_word_t            in_sh_d;
    logic                 word_end;
    logic                 more_words;

    // Buffer words leave byte 0 first, each byte MSB first
    function automatic reg_word_t byte_swap(input reg_word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic bit_cnt_t word_slots_m1(input lane_mode_e lane);
        case (lane)
            LANE_X2: return bit_cnt_t'(WORD_BITS / 2 - 1);
            LANE_X4: return bit_cnt_t'(WORD_BITS / 4 - 1);
            default: return bit_cnt_t'(WORD_BITS - 1);
        endcase
    endfunction

    assign busy_o      = (state_q != SEQ_IDLE) && (state_q != SEQ_DONE);
    assign run_o       = !cs_n_q;
    assign cs_n_o      = cs_n_q;
    assign buf_idx_o   = buf_idx_q;
    assign cap_valid_o = cap_valid_q;
    assign cap_word_o  = cap_word_q;

    assign word_end   = sclk_rise_i && (state_q == SEQ_DATA) && (bit_cnt_q == '0);
    assign more_words = (state_q == SEQ_DATA) && (word_cnt_q != '0);

    // Phase that follows the current one once its last bit has gone out
    always_comb begin
        next_phase = SEQ_DONE;
        if ((state_q == SEQ_CMD) && addr_en_q) begin
            next_phase = SEQ_ADDR;
        end else if (((state_q == SEQ_CMD) || (state_q == SEQ_ADDR)) && (dummy_q != '0)) begin
            next_phase = SEQ_DUMMY;
        end else if ((state_q != SEQ_DATA) && (lane_q != LANE_NONE)) begin
            next_phase = SEQ_DATA;
        end
    end

    // io1 carries the higher bit on two lanes, io3 the highest on four
    always_comb begin
        unique case (lane_q)
            LANE_X2: in_sh_d = {in_sh_q[29:0], io_i[1:0]};
            LANE_X4: in_sh_d = {in_sh_q[27:0], io_i};
            default: in_sh_d = {in_sh_q[30:0], io_i[1]};
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Control state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= SEQ_IDLE;
            cs_n_q      <= 1'b1;
            bit_cnt_q   <= '0;
            word_cnt_q  <= '0;
            buf_idx_q   <= '0;
            cap_valid_q <= 1'b0;
        end else begin
            cap_valid_q <= word_end && !wr_q;
            // Writes step ahead so the next word is ready at the boundary
            if ((word_end && wr_q) || cap_valid_q) begin
                buf_idx_q <= buf_idx_q + 1'b1;
            end
            if (!busy_o) begin
                state_q <= SEQ_IDLE;
                cs_n_q  <= 1'b1;
                if (start_i) begin
                    state_q   <= SEQ_CMD;
                    cs_n_q    <= 1'b0;
                    bit_cnt_q <= bit_cnt_t'(CMD_BITS - 1);
                    buf_idx_q <= '0;
                end
            end else if (sclk_fall_i) begin
                if (bit_cnt_q != '0) begin
                    bit_cnt_q <= bit_cnt_q - 1'b1;
                end else if (more_words) begin
                    word_cnt_q <= word_cnt_q - 1'b1;
                    bit_cnt_q  <= word_slots_m1(lane_q);
                end else begin
                    state_q <= next_phase;
                    case (next_phase)
                        SEQ_ADDR: bit_cnt_q <= bit_cnt_t'(ADDR_BITS - 1);
                        SEQ_DUMMY: bit_cnt_q <= bit_cnt_t'(dummy_q) - 1'b1;
                        SEQ_DATA: begin
                            bit_cnt_q  <= word_slots_m1(lane_q);
                            word_cnt_q <= words_m1_q;
                        end
                        default: cs_n_q <= 1'b1;
                    endcase
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Fields and shift registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (start_i && !busy_o) begin
            lane_q     <= lane_mode_e'(ccr_i.lane_mode);
            wr_q       <= ccr_i.write;
            addr_en_q  <= ccr_i.addr_en;
            dummy_q    <= ccr_i.dummy_cycles;
            words_m1_q <= ccr_i.word_count_m1;
            addr_q     <= flash_addr_i;
            out_sh_q   <= {ccr_i.cmd, 24'h000000};
        end else if (busy_o && sclk_fall_i) begin
            if (bit_cnt_q != '0) begin
                if (state_q != SEQ_DATA || lane_q == LANE_X1) begin
                    out_sh_q <= out_sh_q << 1;
                end else if (lane_q == LANE_X2) begin
                    out_sh_q <= out_sh_q << 2;
                end else begin
                    out_sh_q <= out_sh_q << 4;
                end
            end else if (more_words || next_phase == SEQ_DATA) begin
                out_sh_q <= byte_swap(buf_word_i);
            end else if (next_phase == SEQ_ADDR) begin
                out_sh_q <= {addr_q, 8'h00};
            end else begin
                out_sh_q <= '0;
            end
        end
        if (sclk_rise_i && (state_q == SEQ_DATA) && !wr_q) begin
            in_sh_q <= in_sh_d;
        end
        if (word_end) begin
            cap_word_q <= byte_swap(in_sh_d);
        end
    end

    // Outside quad mode io2 and io3 stay high as WP# and HOLD#
    always_comb begin
        pads_o.io_o  = '0;
        pads_o.io_oe = '0;
        if (busy_o) begin
            pads_o.io_o  = {2'b11, 1'b0, out_sh_q[31]};
            pads_o.io_oe = 4'b1101;
            if (state_q == SEQ_DATA) begin
                unique case (lane_q)
                    LANE_X2: begin
                        pads_o.io_o[1:0] = out_sh_q[31:30];
                        pads_o.io_oe     = wr_q ? 4'b1111 : 4'b1100;
                    end
                    LANE_X4: begin
                        pads_o.io_o  = out_sh_q[31:28];
                        pads_o.io_oe = wr_q ? 4'b1111 : 4'b0000;
                    end
                    default: begin
                        // Single lane reads keep io0 driven low
                        if (!wr_q) begin
                            pads_o.io_o[0] = 1'b0;
                        end
                    end
                endcase
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q == SEQ_IDLE) |-> cs_n_o);

endmodule

// File: rtl/qspi_sclk_gen.sv
`timescale 1ns/100ps

module qspi_sclk_gen
    import qspi_link_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      run_i,
    input  prescale_t prescaler_i,
    output logic      sclk_o,
    output logic      sclk_rise_o,
    output logic      sclk_fall_o
);

    prescale_t div_cnt_q;
    logic      sclk_q;
    logic      toggle;

    // Half period is prescaler + 1 system clocks
    assign toggle = run_i && (div_cnt_q == prescaler_i);

    // Strobes lead the pin edge by one cycle, so the sequencer acts
    // on the same clock edge that moves sclk
    assign sclk_rise_o = toggle && !sclk_q;
    assign sclk_fall_o = toggle && sclk_q;
    assign sclk_o      = sclk_q;

    always_ff @(posedge clk_i) begin
        if (rst_i || !run_i) begin
            div_cnt_q <= '0;
            sclk_q    <= 1'b0;
        end else if (toggle) begin
            div_cnt_q <= '0;
            sclk_q    <= !sclk_q;
        end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
        end
    end

    // Mode 0 idle level, the sequencer must stop only after a falling edge
    assert property (@(posedge clk_i) disable iff (rst_i)
        !run_i |-> !sclk_o);

endmodule

// File: rtl/qspi_regs.sv
`timescale 1ns/100ps

module qspi_regs
    import qspi_reg_pkg::*;
    import qspi_link_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 write_i,
    input  byte_en_t             data_be_i,
    input  reg_addr_t            addr_i,
    input  reg_word_t            wdata_i,
    output reg_word_t            rdata_o,
    input  logic                 busy_i,
    input  buf_idx_t             buf_idx_i,
    input  logic                 cap_valid_i,
    input  reg_word_t            cap_word_i,
    output ccr_t                 ccr_o,
    output logic [ADDR_BITS-1:0] flash_addr_o,
    output logic                 start_o,
    output reg_word_t            buf_word_o
);

    ccr_t                 ccr_q;
    ccr_t                 ccr_d;
    logic [ADDR_BITS-1:0] adr_q;
    reg_word_t            buf_q [BUF_WORDS];
    reg_word_t            rdata_q;
    reg_addr_t            word_addr;
    reg_addr_t            dr_ofs;
    buf_idx_t             dr_idx;
    logic                 dr_hit;
    logic                 ccr_wr;
    logic                 adr_wr;
    logic                 dr_wr;

    function automatic reg_word_t merge_bytes(input reg_word_t cur, input reg_word_t upd,
                                              input byte_en_t be);
        reg_word_t res;
        res = cur;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = upd[8*b +: 8];
            end
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    assign word_addr = {addr_i[5:2], 2'b00};
    assign dr_ofs    = word_addr - DR_OFS;
    assign dr_idx    = dr_ofs[4:2];
    assign dr_hit    = (word_addr >= DR_OFS) && (word_addr < STA_OFS);

    // The command word is frozen while a transfer runs
    assign ccr_wr = write_i && (word_addr == CCR_OFS) && !busy_i;
    assign adr_wr = write_i && (word_addr == ADR_OFS);
    assign dr_wr  = write_i && dr_hit;

    // Fields are passed on as they are being written, so a start in the same
    // write already sees its own prescaler and mode
    always_comb begin
        ccr_d = ccr_q;
        if (ccr_wr) begin
            ccr_d       = ccr_t'(merge_bytes(reg_word_t'(ccr_q), wdata_i, data_be_i));
            ccr_d.start = 1'b0;
            ccr_d.rsvd  = '0;
        end
    end

    assign ccr_o        = ccr_d;
    assign start_o      = ccr_wr && data_be_i[3] && wdata_i[31];
    assign flash_addr_o = adr_q;
    assign buf_word_o   = buf_q[buf_idx_i];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ccr_q <= '0;
            adr_q <= '0;
        end else begin
            ccr_q <= ccr_d;
            if (adr_wr) begin
                adr_q <= ADDR_BITS'(merge_bytes({8'h00, adr_q}, wdata_i,
                                                data_be_i & 4'b0111));
            end
        end
    end

    // Read data from the flash takes priority over the bus
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < BUF_WORDS; i++) begin
            if (cap_valid_i && (buf_idx_i == buf_idx_t'(i))) begin
                buf_q[i] <= cap_word_i;
            end else if (dr_wr && (dr_idx == buf_idx_t'(i))) begin
                buf_q[i] <= merge_bytes(buf_q[i], wdata_i, data_be_i);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Registered read mux
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        rdata_q <= '0;
        if (word_addr == CCR_OFS) begin
            rdata_q <= ccr_q;
        end else if (word_addr == ADR_OFS) begin
            rdata_q <= {8'h00, adr_q};
        end else if (dr_hit) begin
            rdata_q <= buf_q[dr_idx];
        end else if (word_addr == STA_OFS) begin
            rdata_q <= {31'h0, busy_i};
        end
    end

    assign rdata_o = rdata_q;

    // A launch comes only from idle and the sequencer goes busy right after
    assert property (@(posedge clk_i) disable iff (rst_i)
        start_o |-> !busy_i ##1 busy_i);

endmodule

// File: rtl/qspi_link_pkg.sv
package qspi_link_pkg;

    ////////////////////////////////////////////////////////////
    // Serial frame sizes
    ////////////////////////////////////////////////////////////

    localparam int CMD_BITS  = 8;
    localparam int ADDR_BITS = 24;
    localparam int WORD_BITS = 32;

    // Encoding matches the lane_mode field of the command-control word
    typedef enum logic [1:0] {
        LANE_NONE = 2'd0,
        LANE_X1   = 2'd1,
        LANE_X2   = 2'd2,
        LANE_X4   = 2'd3
    } lane_mode_e;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_CMD,
        SEQ_ADDR,
        SEQ_DUMMY,
        SEQ_DATA,
        SEQ_DONE
    } seq_state_e;

    typedef logic [5:0] prescale_t;
    typedef logic [7:0] bit_cnt_t;
    typedef logic [2:0] buf_idx_t;

    // Pad drivers, split so no tristate net lives inside the design
    typedef struct packed {
        logic [3:0] io_o;
        logic [3:0] io_oe;
    } qspi_pads_t;

endpackage

// File: rtl/qspi_reg_pkg.sv
package qspi_reg_pkg;

    ////////////////////////////////////////////////////////////
    // Register bus types
    ////////////////////////////////////////////////////////////

    // Byte address on the register bus
    typedef logic [5:0]  reg_addr_t;
    typedef logic [31:0] reg_word_t;
    typedef logic [3:0]  byte_en_t;

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////

    localparam reg_addr_t CCR_OFS = 6'd0;
    localparam reg_addr_t ADR_OFS = 6'd4;
    // Data buffer words sit at 8, 12, ... 36
    localparam reg_addr_t DR_OFS  = 6'd8;
    localparam reg_addr_t STA_OFS = 6'd40;

    localparam int BUF_WORDS = 8;

    // Command-control word, listed from bit 31 down
    typedef struct packed {
        logic       start;
        logic [5:0] prescaler;
        logic [5:0] rsvd;
        logic [2:0] word_count_m1;
        logic [3:0] dummy_cycles;
        logic       addr_en;
        logic       write;
        logic [1:0] lane_mode;
        logic [7:0] cmd;
    } ccr_t;

endpackage
